// File: include/rvseed_macros.svh
`ifndef RVSEED_MACROS_SVH
`define RVSEED_MACROS_SVH

`define CPU_WIDTH      64
`define INST_WIDTH     32
`define REG_DATA_DEPTH 32
`define RESET_PC       64'h0000_0000_8000_0000

`define OPC_OP_IMM     7'b0010011
`define OPC_BRANCH     7'b1100011
`define OPC_JAL        7'b1101111
`define OPC_JALR       7'b1100111
`define OPC_SYSTEM     7'b1110011

`endif

// File: hw/rvseed_pkg.sv
`include "rvseed_macros.svh"

package rvseed_pkg;

   // register, pc or immediate value
   typedef logic [`CPU_WIDTH-1:0] xlen_t;

   typedef logic [`INST_WIDTH-1:0] inst_t;

   typedef logic [$clog2(`REG_DATA_DEPTH)-1:0] reg_addr_t;

   // mcycle / minstret style
   typedef logic [63:0] cnt_t;

   typedef enum logic [2:0] {
      ALU_NONE,
      ALU_ADD,
      ALU_BEQ,
      ALU_BNE,
      ALU_BLT,
      ALU_BMT,   // signed >=
      ALU_BLTU,
      ALU_BMTU   // unsigned >=
   } alu_op_t;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_FETCH,
      ST_EXEC,
      ST_HALT
   } core_state_t;

endpackage

// File: hw/rvseed_ctrl_fsm.sv
`include "rvseed_macros.svh"

module rvseed_ctrl_fsm (
   input  logic              clk,
   input  logic              reset,
   input  logic              run,
   input  logic              ebreak,
   input  rvseed_pkg::xlen_t next_pc,
   output logic              fetch,
   output logic              exec_en,
   output logic              halted,
   output logic              busy,
   output rvseed_pkg::xlen_t pc
);
   import rvseed_pkg::*;

   core_state_t state;
   core_state_t state_nxt;

   always_comb begin
      state_nxt = state;
      case (state)
         ST_IDLE: begin
            if (run) begin
               state_nxt = ST_FETCH;
            end
         end
         ST_FETCH: state_nxt = ST_EXEC;
         ST_EXEC: begin
            if (ebreak) begin
               state_nxt = ST_HALT;
            end else if (run) begin
               state_nxt = ST_FETCH;   // back to back
            end else begin
               state_nxt = ST_IDLE;
            end
         end
         default: state_nxt = ST_HALT;   // only reset leaves halt
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= ST_IDLE;
         pc    <= `RESET_PC;
      end else begin
         state <= state_nxt;
         if (state == ST_EXEC) begin
            pc <= ebreak ? `RESET_PC : next_pc;
         end
      end
   end

   assign fetch   = (state == ST_FETCH);
   assign exec_en = (state == ST_EXEC);
   assign halted  = (state == ST_HALT);
   assign busy    = fetch | exec_en;

endmodule

// File: hw/rvseed_perf_counter.sv
module rvseed_perf_counter (
   input  logic             clk,
   input  logic             reset,
   input  logic             busy,
   input  logic             retire,
   output rvseed_pkg::cnt_t cycle_cnt,
   output rvseed_pkg::cnt_t instret_cnt
);

   // cycles spent in fetch or exec
   always_ff @(posedge clk) begin
      if (reset) begin
         cycle_cnt <= '0;
      end else if (busy) begin
         cycle_cnt <= cycle_cnt + 64'd1;   // wraps
      end
   end

   // one per exec cycle, ebreak included
   always_ff @(posedge clk) begin
      if (reset) begin
         instret_cnt <= '0;
      end else if (retire) begin
         instret_cnt <= instret_cnt + 64'd1;
      end
   end

endmodule

// File: hw/rvseed_decode.sv
`include "rvseed_macros.svh"

module rvseed_decode (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  fetch,
   input  rvseed_pkg::inst_t     inst,
   output rvseed_pkg::reg_addr_t rs1_addr,
   output rvseed_pkg::reg_addr_t rs2_addr,
   output rvseed_pkg::reg_addr_t rd_addr,
   output rvseed_pkg::xlen_t     imm,
   output rvseed_pkg::alu_op_t   alu_op,
   output logic                  branch,
   output logic                  jump,
   output logic                  jalr,
   output logic                  ebreak,
   output logic                  rd_we
);
   import rvseed_pkg::*;

   inst_t      ir;
   logic [6:0] opcode;
   logic [2:0] funct3;

   always_ff @(posedge clk) begin
      if (reset) begin
         ir <= '0;   // decodes as a no-op
      end else if (fetch) begin
         ir <= inst;
      end
   end

   assign opcode   = ir[6:0];
   assign funct3   = ir[14:12];
   assign rs1_addr = ir[19:15];
   assign rs2_addr = ir[24:20];
   assign rd_addr  = ir[11:7];

   always_comb begin
      imm    = '0;
      alu_op = ALU_NONE;
      branch = 1'b0;
      jump   = 1'b0;
      jalr   = 1'b0;
      ebreak = 1'b0;
      rd_we  = 1'b0;
      case (opcode)
         `OPC_OP_IMM: begin
            if (funct3 == 3'b000) begin   // addi only
               imm    = {{(`CPU_WIDTH-12){ir[31]}}, ir[31:20]};
               alu_op = ALU_ADD;
               rd_we  = 1'b1;
            end
         end
         `OPC_BRANCH: begin
            imm    = {{(`CPU_WIDTH-13){ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
            branch = (funct3 != 3'b010) && (funct3 != 3'b011);
            case (funct3)
               3'b000:  alu_op = ALU_BEQ;
               3'b001:  alu_op = ALU_BNE;
               3'b100:  alu_op = ALU_BLT;
               3'b101:  alu_op = ALU_BMT;
               3'b110:  alu_op = ALU_BLTU;
               3'b111:  alu_op = ALU_BMTU;
               default: alu_op = ALU_NONE;
            endcase
         end
         `OPC_JAL: begin
            imm   = {{(`CPU_WIDTH-21){ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
            jump  = 1'b1;
            rd_we = 1'b1;
         end
         `OPC_JALR: begin
            if (funct3 == 3'b000) begin
               imm    = {{(`CPU_WIDTH-12){ir[31]}}, ir[31:20]};
               alu_op = ALU_ADD;
               jump   = 1'b1;
               jalr   = 1'b1;
               rd_we  = 1'b1;
            end
         end
         `OPC_SYSTEM: begin
            ebreak = (funct3 == 3'b000) && (ir[31:20] == 12'h001);
         end
         default: ;
      endcase
   end

endmodule

// File: hw/rvseed_regfile.sv
`include "rvseed_macros.svh"

module rvseed_regfile (
   input  logic                  clk,
   input  logic                  reset,
   input  rvseed_pkg::reg_addr_t rs1_addr,
   input  rvseed_pkg::reg_addr_t rs2_addr,
   output rvseed_pkg::xlen_t     rs1_data,
   output rvseed_pkg::xlen_t     rs2_data,
   input  rvseed_pkg::reg_addr_t rd_addr,
   input  rvseed_pkg::xlen_t     wb_data,
   input  logic                  we
);
   import rvseed_pkg::*;

   xlen_t regs [`REG_DATA_DEPTH];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < `REG_DATA_DEPTH; i++) begin
            regs[i] <= '0;
         end
      end else if (we && (rd_addr != '0)) begin   // x0 stays zero
         regs[rd_addr] <= wb_data;
      end
   end

   // async read
   assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
   assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// File: hw/rvseed_exec.sv
`include "rvseed_macros.svh"

module rvseed_exec (
   input  rvseed_pkg::xlen_t   pc,
   input  rvseed_pkg::xlen_t   imm,
   input  rvseed_pkg::xlen_t   rs1_data,
   input  rvseed_pkg::xlen_t   rs2_data,
   input  rvseed_pkg::alu_op_t alu_op,
   input  logic                branch,
   input  logic                jump,
   input  logic                jalr,
   input  logic                ebreak,
   output rvseed_pkg::xlen_t   next_pc,
   output rvseed_pkg::xlen_t   wb_data
);
   import rvseed_pkg::*;

   logic  taken;
   xlen_t pc_plus4;
   xlen_t pc_plus_imm;
   xlen_t rs1_plus_imm;

   assign pc_plus4     = pc + `CPU_WIDTH'd4;
   assign pc_plus_imm  = pc + imm;
   assign rs1_plus_imm = rs1_data + imm;

   always_comb begin
      case (alu_op)
         ALU_BEQ:  taken = (rs1_data == rs2_data);
         ALU_BNE:  taken = (rs1_data != rs2_data);
         ALU_BLT:  taken = ($signed(rs1_data) < $signed(rs2_data));
         ALU_BMT:  taken = ($signed(rs1_data) >= $signed(rs2_data));
         ALU_BLTU: taken = (rs1_data < rs2_data);
         ALU_BMTU: taken = (rs1_data >= rs2_data);
         default:  taken = 1'b0;
      endcase
   end

   always_comb begin
      if (branch && taken) begin
         next_pc = pc_plus_imm;
      end else if (jump && !jalr) begin   // jal
         next_pc = pc_plus_imm;
      end else if (jump && jalr) begin
         next_pc = {rs1_plus_imm[`CPU_WIDTH-1:1], 1'b0};   // lsb cleared
      end else if (ebreak) begin
         next_pc = `RESET_PC;
      end else begin
         next_pc = pc_plus4;   // fall through, not-taken, no-op
      end
   end

   // link for jal/jalr, addi result otherwise
   assign wb_data = jump ? pc_plus4 : rs1_plus_imm;

endmodule

// File: hw/rvseed_branch_core.sv
module rvseed_branch_core (
   input  logic              clk,
   input  logic              reset,
   input  logic              run,
   input  rvseed_pkg::inst_t inst,
   output logic              fetch,
   output rvseed_pkg::xlen_t pc,
   output logic              halted,
   output rvseed_pkg::cnt_t  cycle_cnt,
   output rvseed_pkg::cnt_t  instret_cnt
);
   import rvseed_pkg::*;

   logic      exec_en;
   logic      busy;
   reg_addr_t rs1_addr;
   reg_addr_t rs2_addr;
   reg_addr_t rd_addr;
   xlen_t     imm;
   xlen_t     rs1_data;
   xlen_t     rs2_data;
   xlen_t     next_pc;
   xlen_t     wb_data;
   alu_op_t   alu_op;
   logic      branch;
   logic      jump;
   logic      jalr;
   logic      ebreak;
   logic      rd_we;

   rvseed_ctrl_fsm u_ctrl (
      .clk, .reset, .run, .ebreak, .next_pc,
      .fetch, .exec_en, .halted, .busy, .pc
   );

   rvseed_perf_counter u_perf (
      .clk, .reset, .busy, .retire(exec_en), .cycle_cnt, .instret_cnt
   );

   rvseed_decode u_decode (
      .clk, .reset, .fetch, .inst, .rs1_addr, .rs2_addr, .rd_addr, .imm,
      .alu_op, .branch, .jump, .jalr, .ebreak, .rd_we
   );

   rvseed_regfile u_regfile (
      .clk, .reset, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
      .rd_addr, .wb_data,
      .we(exec_en & rd_we)   // write back in the exec cycle
   );

   rvseed_exec u_exec (
      .pc, .imm, .rs1_data, .rs2_data, .alu_op, .branch, .jump, .jalr,
      .ebreak, .next_pc, .wb_data
   );

endmodule

// File: dv/rvseed_checker.sv
module rvseed_checker (
   input logic              clk,
   input logic              reset,
   input logic              fetch,
   input logic              halted,
   input logic              exec_en,
   input rvseed_pkg::xlen_t pc
);

   // one fetch per instruction, never back to back
   a_fetch_single: assert property (@(posedge clk) disable iff (reset)
      fetch |=> !fetch)
      else $error("fetch high on two consecutive cycles");

   // halt is left only through reset
   a_halt_sticky: assert property (@(posedge clk) disable iff (reset)
      halted |=> (halted && !fetch))
      else $error("halted dropped or fetch rose while halted");

   // pc moves only on the edge that ends an exec cycle
   a_pc_hold: assert property (@(posedge clk) disable iff (reset)
      !exec_en |=> $stable(pc))
      else $error("pc changed outside of an exec cycle");

endmodule

bind rvseed_branch_core rvseed_checker u_checker (
   .clk, .reset, .fetch, .halted, .exec_en, .pc
);

// File: dv/rvseed_tb.sv
`include "rvseed_macros.svh"

module rvseed_tb;
   import rvseed_pkg::*;

   logic  clk;
   logic  reset;
   logic  run;
   inst_t inst;
   logic  fetch;
   xlen_t pc;
   logic  halted;
   cnt_t  cycle_cnt;
   cnt_t  instret_cnt;

   xlen_t row_pc[$];     // expected fetch address
   inst_t row_inst[$];
   string row_tag[$];
   bit    rows_loaded;

   rvseed_branch_core dut (
      .clk, .reset, .run, .inst, .fetch, .pc, .halted, .cycle_cnt, .instret_cnt
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic report_failure(input string line);
      $display("%s", line);
      $display("Finished with errors");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         report_failure($sformatf("CHECK FAILED at %0t: %s is 0x%0h, expected 0x%0h",
                                  $time, name, got, exp));
      end
   endtask

   function automatic inst_t enc_addi(input reg_addr_t rd, input reg_addr_t rs1,
                                      input logic [11:0] imm);
      return {imm, rs1, 3'b000, rd, `OPC_OP_IMM};
   endfunction

   // b-type immediate is scattered over the word
   function automatic inst_t enc_branch(input logic [2:0] f3, input reg_addr_t rs1,
                                        input reg_addr_t rs2, input logic [12:0] off);
      return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `OPC_BRANCH};
   endfunction

   function automatic inst_t enc_jal(input reg_addr_t rd, input logic [20:0] off);
      return {off[20], off[10:1], off[11], off[19:12], rd, `OPC_JAL};
   endfunction

   function automatic inst_t enc_jalr(input reg_addr_t rd, input reg_addr_t rs1,
                                      input logic [11:0] imm);
      return {imm, rs1, 3'b000, rd, `OPC_JALR};
   endfunction

   task automatic add_row(input logic [7:0] off, input inst_t word, input string tag);
      row_pc.push_back(`RESET_PC + {56'd0, off});
      row_inst.push_back(word);
      row_tag.push_back(tag);
   endtask

   task automatic wait_for_fetch(input int row);
      while (!fetch) begin
         if (halted) begin
            report_failure($sformatf("core halted before reaching row %0d", row));
         end
         @(negedge clk);
      end
   endtask

   // x1 = 5, x2 = -3, x3 = 5; taken branches skip one word
   task automatic load_program();
      add_row(8'h00, enc_addi(5'd1, 5'd0, 12'd5), "addi x1 5");
      add_row(8'h04, enc_addi(5'd2, 5'd0, 12'hffd), "addi x2 -3");
      add_row(8'h08, enc_addi(5'd3, 5'd0, 12'd5), "addi x3 5");
      add_row(8'h0c, enc_branch(3'b000, 5'd1, 5'd3, 13'd8), "beq taken");
      add_row(8'h14, enc_branch(3'b000, 5'd1, 5'd2, 13'd8), "beq not taken");
      add_row(8'h18, enc_branch(3'b001, 5'd1, 5'd2, 13'd8), "bne taken");
      add_row(8'h20, enc_branch(3'b001, 5'd1, 5'd3, 13'd8), "bne not taken");
      add_row(8'h24, enc_branch(3'b100, 5'd2, 5'd1, 13'd8), "blt taken");
      add_row(8'h2c, enc_branch(3'b110, 5'd2, 5'd1, 13'd8), "bltu not taken");
      add_row(8'h30, enc_branch(3'b100, 5'd1, 5'd2, 13'd8), "blt not taken");
      add_row(8'h34, enc_branch(3'b110, 5'd1, 5'd2, 13'd8), "bltu taken");
      add_row(8'h3c, enc_branch(3'b101, 5'd1, 5'd2, 13'd8), "bge taken");
      add_row(8'h44, enc_branch(3'b111, 5'd1, 5'd2, 13'd8), "bgeu not taken");
      add_row(8'h48, enc_branch(3'b101, 5'd2, 5'd1, 13'd8), "bge not taken");
      add_row(8'h4c, enc_branch(3'b111, 5'd2, 5'd1, 13'd8), "bgeu taken");
      add_row(8'h54, enc_jal(5'd5, 21'd20), "jal x5");   // link 0x58
      add_row(8'h68, enc_jalr(5'd0, 5'd5, 12'd1), "jalr odd offset");
      add_row(8'h58, enc_addi(5'd4, 5'd0, 12'd3), "addi x4 3");
      add_row(8'h5c, enc_addi(5'd4, 5'd4, 12'd1), "x4 to 4");
      add_row(8'h60, enc_branch(3'b001, 5'd4, 5'd1, 13'h1ffc), "bne back taken");
      add_row(8'h5c, enc_addi(5'd4, 5'd4, 12'd1), "x4 to 5");
      add_row(8'h60, enc_branch(3'b001, 5'd4, 5'd1, 13'h1ffc), "bne back not taken");
      add_row(8'h64, 32'h0010_0073, "ebreak");
   endtask

   initial begin
      wait (rows_loaded);
      #((row_pc.size() * 2 + 20) * 20);
      report_failure("timeout: the program did not reach halt in time");
   end

   initial begin
      reset = 1'b1;
      run   = 1'b0;
      inst  = '0;
      load_program();
      rows_loaded = 1'b1;

      repeat (2) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      @(negedge clk);
      check("pc after reset", pc, `RESET_PC);
      check("fetch after reset", 64'(fetch), 64'd0);
      check("halted after reset", 64'(halted), 64'd0);
      check("cycle_cnt after reset", cycle_cnt, 64'd0);
      check("instret_cnt after reset", instret_cnt, 64'd0);
      run = 1'b1;

      for (int i = 0; i < row_pc.size(); i++) begin
         wait_for_fetch(i);
         check({"pc at ", row_tag[i]}, pc, row_pc[i]);
         check({"instret_cnt at ", row_tag[i]}, instret_cnt, 64'(i));
         check({"cycle_cnt at ", row_tag[i]}, cycle_cnt, 64'(2 * i));
         inst = row_inst[i];
         @(negedge clk);   // exec cycle
      end

      @(negedge clk);
      check("halted after ebreak", 64'(halted), 64'd1);
      check("pc after ebreak", pc, `RESET_PC);
      check("instret_cnt at halt", instret_cnt, 64'(row_pc.size()));
      check("cycle_cnt at halt", cycle_cnt, 64'(2 * row_pc.size()));
      repeat (10) begin
         @(negedge clk);
         check("fetch while halted", 64'(fetch), 64'd0);
         check("halted held", 64'(halted), 64'd1);
      end

      $display("Finished with no errors");
      $finish;
   end

endmodule

// File: build.f
+incdir+include
hw/rvseed_pkg.sv
hw/rvseed_ctrl_fsm.sv
hw/rvseed_perf_counter.sv
hw/rvseed_decode.sv
hw/rvseed_regfile.sv
hw/rvseed_exec.sv
hw/rvseed_branch_core.sv
dv/rvseed_checker.sv
dv/rvseed_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the branch core testbench with Verilator
verilator --binary --timing --assert -f build.f --top-module rvseed_tb -o rvseed_sim \
   && ./obj_dir/rvseed_sim | tee /dev/stderr | grep -q "Finished with no errors" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
